// File: Bender.yml
package:
  name: lockstep_sequencer

sources:
  - include_dirs:
      - include
    files:
      - hdl/lockstep_pkg.sv
      - hdl/phase_sequencer.sv
      - hdl/onehot_compare.sv
      - hdl/lockstep_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - verif/lockstep_sva.sv
      - verif/lockstep_tb.sv

// File: hdl/lockstep_pkg.sv
// shared widths and types of the lockstep sequencer, compiled ahead of all RTL
package lockstep_pkg;

`include "lockstep_defs.svh"

    // ring length, one bit per phase
    localparam int NUM_STATES = `LOCKSTEP_NUM_STATES;

    // popcount width, holds 0 up to NUM_STATES
    localparam int COUNT_W = $clog2(NUM_STATES) + 1;

    // heap-ordered adder tree, leaves at NUM_STATES..2*NUM_STATES-1
    localparam int TREE_NODES = 2 * NUM_STATES;

    typedef logic [NUM_STATES-1:0] phase_t;

    // reset and clear phase
    localparam phase_t PHASE_ZERO = phase_t'(1);

    // registered comparison of the two copies
    typedef struct packed {
        logic   valid_a;
        logic   valid_b;
        logic   equal;
        phase_t common;
    } cmp_result_t;

    localparam cmp_result_t RESULT_CLEAR = '0;

endpackage

// File: hdl/lockstep_top.sv
// lockstep pair of phase sequencers on shared commands, checked by the one-hot comparator
module lockstep_top
    import lockstep_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clear,
    input  logic        step,
    input  logic        upset_a,
    input  logic        upset_b,
    input  phase_t      upset_mask_a,
    input  phase_t      upset_mask_b,
    output phase_t      phase_a,
    output phase_t      phase_b,
    output cmp_result_t result,
    output logic        alarm
);

    // copy A
    phase_sequencer seq_a (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear),
        .step       (step),
        .upset      (upset_a),
        .upset_mask (upset_mask_a),
        .phase      (phase_a)
    );

    // copy B, same commands, its own fault port
    phase_sequencer seq_b (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear),
        .step       (step),
        .upset      (upset_b),
        .upset_mask (upset_mask_b),
        .phase      (phase_b)
    );

    // result lags the phases by one edge
    onehot_compare cmp (
        .clk     (clk),
        .rst_n   (rst_n),
        .phase_a (phase_a),
        .phase_b (phase_b),
        .result  (result),
        .alarm   (alarm)
    );

endmodule

// File: hdl/onehot_compare.sv
// checks two phase words for one-hot encoding and agreement, with a sticky alarm
module onehot_compare
    import lockstep_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  phase_t      phase_a,
    input  phase_t      phase_b,
    output cmp_result_t result,
    output logic        alarm
);

    phase_t             words [2];
    logic [COUNT_W-1:0] count [2];
    logic [1:0]         word_valid;
    logic               words_equal;
    phase_t             common_bits;
    cmp_result_t        result_d;
    cmp_result_t        result_q;
    logic               result_live;
    logic               fault;
    logic               alarm_q;

    genvar w;
    genvar n;

    // index 0 is copy A, index 1 is copy B
    assign words[0] = phase_a;
    assign words[1] = phase_b;

    // one pairwise adder tree per word
    generate
        for (w = 0; w < 2; w++) begin : g_word
            logic [COUNT_W-1:0] node [1:TREE_NODES-1];

            // leaves are the word's bits
            for (n = 0; n < NUM_STATES; n++) begin : g_leaf
                assign node[NUM_STATES+n] = COUNT_W'(words[w][n]);
            end

            // each inner node sums its two children, node 1 is the total
            for (n = 1; n < NUM_STATES; n++) begin : g_sum
                assign node[n] = node[2*n] + node[2*n+1];
            end

            assign count[w]      = node[1];
            assign word_valid[w] = (count[w] == COUNT_W'(1));
        end
    endgenerate

    // equal means bitwise identical, nothing looser
    assign words_equal = (phase_a == phase_b);
    assign common_bits = phase_a & phase_b;

    always_comb begin
        result_d         = RESULT_CLEAR;
        result_d.valid_a = word_valid[0];
        result_d.valid_b = word_valid[1];
        result_d.equal   = words_equal;
        result_d.common  = common_bits;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_q <= RESULT_CLEAR;
        end else begin
            result_q <= result_d;
        end
    end

    // the cleared result right after reset is not a real comparison
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_live <= 1'b0;
        end else begin
            result_live <= 1'b1;
        end
    end

    // divergence or a bad encoding on either copy
    assign fault = !(result_q.equal && result_q.valid_a && result_q.valid_b);

    // sticky until reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alarm_q <= 1'b0;
        end else if (result_live && fault) begin
            alarm_q <= 1'b1;
        end
    end

    assign result = result_q;
    assign alarm  = alarm_q;

endmodule

// File: hdl/phase_sequencer.sv
// one-hot phase register with clear, step and soft-error injection, one per lockstep copy
module phase_sequencer
    import lockstep_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   clear,
    input  logic   step,
    input  logic   upset,
    input  phase_t upset_mask,
    output phase_t phase
);

    phase_t phase_q;
    phase_t rotated;
    phase_t advanced;
    phase_t phase_d;

    // rotate up by one, top bit wraps into bit 0
    assign rotated = {phase_q[NUM_STATES-2:0], phase_q[NUM_STATES-1]};

    // clear wins over step
    always_comb begin
        if (clear) begin
            advanced = PHASE_ZERO;
        end else if (step) begin
            advanced = rotated;
        end else begin
            advanced = phase_q;
        end
    end

    // fault port flips bits on top of the command update,
    // so the stored word may no longer be one-hot
    always_comb begin
        if (upset) begin
            phase_d = advanced ^ upset_mask;
        end else begin
            phase_d = advanced;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase_q <= PHASE_ZERO;
        end else begin
            phase_q <= phase_d;
        end
    end

    assign phase = phase_q;

endmodule

// File: include/lockstep_defs.svh
// phase-word width for the lockstep design, pulled in by the package only
`ifndef LOCKSTEP_DEFS_SVH
`define LOCKSTEP_DEFS_SVH

// number of phases in one sequencer ring
// widening this also widens every phase word and the compare result
`define LOCKSTEP_NUM_STATES 8

`endif

// File: list.f
+incdir+include
hdl/lockstep_pkg.sv
hdl/phase_sequencer.sv
hdl/onehot_compare.sv
hdl/lockstep_top.sv
verif/lockstep_sva.sv
verif/lockstep_tb.sv

// File: verif/lockstep_sva.sv
// concurrent assertions on the one-hot comparator, attached to every instance by bind
module lockstep_sva
    import lockstep_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input phase_t      phase_a,
    input cmp_result_t result,
    input logic        alarm
);
    timeunit 1ns;
    timeprecision 1ps;

    // count of failed assertions
    int failures = 0;

    // common bits must be the registered copy A word when both agree
    property equal_means_common;
        @(posedge clk) disable iff (!rst_n)
            result.equal |-> (result.common == $past(phase_a));
    endproperty

    // once raised, only reset lowers the alarm
    property alarm_sticky;
        @(posedge clk) disable iff (!rst_n)
            alarm |=> alarm;
    endproperty

    property reset_clears;
        @(posedge clk)
            !rst_n |=> (result == '0 && !alarm);
    endproperty

    a_equal_common : assert property (equal_means_common)
        else begin
            failures++;
            $error("common bits differ from phase A while equal is set");
        end

    a_alarm_sticky : assert property (alarm_sticky)
        else begin
            failures++;
            $error("alarm dropped without reset");
        end

    a_reset_clear : assert property (reset_clears)
        else begin
            failures++;
            $error("result or alarm not cleared after reset");
        end

endmodule

bind onehot_compare lockstep_sva sva_checks (
    .clk     (clk),
    .rst_n   (rst_n),
    .phase_a (phase_a),
    .result  (result),
    .alarm   (alarm)
);

// File: verif/lockstep_tb.sv
// self-checking testbench for lockstep_top, seeded random commands against a behavioral model
module lockstep_tb
    import lockstep_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // one cycle of commands for both copies
    typedef struct packed {
        logic   clear;
        logic   step;
        logic   upset_a;
        logic   upset_b;
        phase_t mask_a;
        phase_t mask_b;
    } stim_t;

    logic        clk;
    logic        rst_n;
    logic        clear;
    logic        step;
    logic        upset_a;
    logic        upset_b;
    phase_t      upset_mask_a;
    phase_t      upset_mask_b;
    phase_t      phase_a;
    phase_t      phase_b;
    cmp_result_t result;
    logic        alarm;

    integer      seed;
    int          checks;
    int          errors;
    int          assert_failures;
    string       test_name;

    // model state
    phase_t      model_a;
    phase_t      model_b;
    cmp_result_t exp_result;
    logic        model_alarm;
    logic        model_live;
    logic        prev_alarm;

    stim_t       s;

    lockstep_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear        (clear),
        .step         (step),
        .upset_a      (upset_a),
        .upset_b      (upset_b),
        .upset_mask_a (upset_mask_a),
        .upset_mask_b (upset_mask_b),
        .phase_a      (phase_a),
        .phase_b      (phase_b),
        .result       (result),
        .alarm        (alarm)
    );

    always #2 clk = ~clk;

    function automatic int roll_percent();
        roll_percent = {$random(seed)} % 100;
    endfunction

    function automatic phase_t random_mask();
        if (roll_percent() < 30) begin
            random_mask = phase_t'(1) << ({$random(seed)} % NUM_STATES);
        end else begin
            random_mask = phase_t'($random(seed));
        end
    endfunction

    function automatic stim_t random_stim(input logic allow_upset);
        stim_t r;
        r.clear   = (roll_percent() < 5);
        r.step    = (roll_percent() < 50);
        r.upset_a = allow_upset && (roll_percent() < 3);
        r.upset_b = allow_upset && (roll_percent() < 3);
        r.mask_a  = random_mask();
        r.mask_b  = random_mask();
        random_stim = r;
    endfunction

    // clear first, then step, then the fault flips
    function automatic phase_t next_phase(input phase_t cur, input logic clr, input logic stp,
                                          input logic up, input phase_t mask);
        phase_t nxt;
        nxt = cur;
        if (clr) begin
            nxt = phase_t'(1);
        end else if (stp) begin
            nxt = {cur[NUM_STATES-2:0], cur[NUM_STATES-1]};
        end
        if (up) begin
            nxt = nxt ^ mask;
        end
        next_phase = nxt;
    endfunction

    function automatic int count_ones(input phase_t word);
        int total;
        total = 0;
        for (int i = 0; i < NUM_STATES; i++) begin
            total += word[i];
        end
        count_ones = total;
    endfunction

    function automatic cmp_result_t expected_compare(input phase_t a, input phase_t b);
        cmp_result_t r;
        r.valid_a = (count_ones(a) == 1);
        r.valid_b = (count_ones(b) == 1);
        r.equal   = (a === b);
        r.common  = a & b;
        expected_compare = r;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error: %s %s expected %0h actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic compare_outputs();
        check_value("phase_a", model_a, phase_a);
        check_value("phase_b", model_b, phase_b);
        check_value("result", exp_result, result);
        check_value("alarm", model_alarm, alarm);
        if (prev_alarm && !alarm) begin
            errors++;
            $display("alarm went low in %s without a reset", test_name);
        end
        prev_alarm = alarm;
    endtask

    // check what the last edge produced, then drive the next command
    task automatic run_cycle(input stim_t st);
        @(negedge clk);
        compare_outputs();
        rst_n        = 1'b1;
        clear        = st.clear;
        step         = st.step;
        upset_a      = st.upset_a;
        upset_b      = st.upset_b;
        upset_mask_a = st.mask_a;
        upset_mask_b = st.mask_b;
        if (model_live && !(exp_result.equal && exp_result.valid_a && exp_result.valid_b)) begin
            model_alarm = 1'b1;
        end
        model_live = 1'b1;
        exp_result = expected_compare(model_a, model_b);
        model_a    = next_phase(model_a, st.clear, st.step, st.upset_a, st.mask_a);
        model_b    = next_phase(model_b, st.clear, st.step, st.upset_b, st.mask_b);
    endtask

    task automatic run_idle();
        run_cycle('0);
    endtask

    // the last command before reset is still checked
    task automatic apply_reset();
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            if (i == 0 && model_live) begin
                compare_outputs();
            end
            rst_n   = 1'b0;
            clear   = 1'b0;
            step    = 1'b0;
            upset_a = 1'b0;
            upset_b = 1'b0;
        end
        model_a     = phase_t'(1);
        model_b     = phase_t'(1);
        exp_result  = '0;
        model_alarm = 1'b0;
        model_live  = 1'b0;
        prev_alarm  = 1'b0;
    endtask

    task automatic wait_for_alarm(input int limit);
        int n;
        n = 0;
        while (!alarm && n < limit) begin
            run_idle();
            n++;
        end
        if (!alarm) begin
            errors++;
            $display("timeout in %s, alarm did not rise within %0d cycles", test_name, limit);
        end
    endtask

    task automatic wait_for_valid(input int limit);
        int n;
        n = 0;
        while (!(result.valid_a && result.valid_b && result.equal) && n < limit) begin
            run_idle();
            n++;
        end
        if (!(result.valid_a && result.valid_b && result.equal)) begin
            errors++;
            $display("timeout in %s, no valid matching result within %0d cycles",
                     test_name, limit);
        end
    endtask

    initial begin
        seed         = 32'h79e7;
        checks       = 0;
        errors       = 0;
        model_live   = 1'b0;
        clk          = 1'b0;
        rst_n        = 1'b0;
        clear        = 1'b0;
        step         = 1'b0;
        upset_a      = 1'b0;
        upset_b      = 1'b0;
        upset_mask_a = '0;
        upset_mask_b = '0;

        test_name = "reset";
        apply_reset();
        wait_for_valid(6);
        check_value("common after reset", phase_t'(1), result.common);

        test_name = "lockstep_run";
        for (int i = 0; i < 200; i++) begin
            run_cycle(random_stim(1'b0));
        end
        check_value("no alarm", 0, alarm);

        // one bit flipped on copy A only
        test_name = "single_upset";
        s = '0;
        s.upset_a = 1'b1;
        s.mask_a  = phase_t'(1) << 5;
        run_cycle(s);
        run_idle();
        run_idle();
        check_value("equal low", 0, result.equal);
        wait_for_alarm(4);

        // cancel the active bit, then several bits at once
        test_name = "mask_validity";
        apply_reset();
        s = '0;
        s.upset_a = 1'b1;
        s.mask_a  = model_a;
        s.upset_b = 1'b1;
        s.mask_b  = 8'hc2;
        run_cycle(s);
        run_idle();
        run_idle();
        check_value("zero word", 0, phase_a);
        check_value("valid_a", 0, result.valid_a);
        check_value("valid_b", 0, result.valid_b);

        test_name = "twin_upset";
        apply_reset();
        s = '0;
        s.step    = 1'b1;
        s.upset_a = 1'b1;
        s.upset_b = 1'b1;
        s.mask_a  = 8'h30;
        s.mask_b  = 8'h30;
        run_cycle(s);
        run_idle();
        run_idle();
        check_value("equal held", 1, result.equal);
        check_value("valid_a", 0, result.valid_a);
        wait_for_alarm(4);

        test_name = "random_run";
        apply_reset();
        for (int i = 1; i <= 2000; i++) begin
            run_cycle(random_stim(1'b1));
            if (i % 128 == 0) begin
                apply_reset();
            end
        end
        run_idle();

        assert_failures = UUT.cmp.sva_checks.failures;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, assert_failures);
        if (errors == 0 && assert_failures == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
